// ==== soc_ifc_cases.txt ====
# op a b c d e, all hex. W: addr wdata pauser - pslverr. R: addr - pauser rdata pslverr
# S: debug_locked generic_in iccm_blocked lifecycle -. O: flow_bits generic_out intr_bits - -
S 0 cafef00d 0 2 0
W 000 00000005 0 0 0
W 00c 12345678 0 0 0
R 000 0 0 00000005 0
R 00c 0 0 12345678 0
R 008 0 0 cafef00d 0
R 004 0 0 00000002 0
O 5 12345678 0 0 0
W 020 11111111 0 0 0
W 010 00000001 0 0 0
W 020 deadbeef 0 0 0
R 020 0 0 11111111 0
O d 12345678 0 0 0
W 040 000000a5 0 0 0
W 048 01020304 a5 0 0
W 048 0badf00d 5a 0 0
R 048 0 a5 01020304 0
W 044 00000001 0 0 0
W 040 0000005a 0 0 0
R 040 0 0 000000a5 0
W 058 00000002 0 0 0
S 1 cafef00d 0 2 0
R 054 0 0 00000001 0
R 004 0 0 00000006 0
O d 12345678 2 0 0
W 054 00000001 0 0 0
O d 12345678 0 0 0
R 030 0 0 0 1
W 008 ffffffff 0 0 1
S 1 cafef00d 1 2 0
S 1 cafef00d 0 2 0
R 050 0 0 00000003 0
O d 12345678 0 0 0

// ==== soc_ifc_top.f ====
soc_ifc_pkg.sv
soc_ifc_reg_pkg.sv
soc_ifc_req_if.sv
apb_slv_sif.sv
soc_ifc_regs.sv
soc_ifc_intr.sv
soc_ifc_top.sv
soc_ifc_top_sva.sv
soc_ifc_top_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the SoC interface testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module soc_ifc_top_tb -f soc_ifc_top.f -o sim_soc_ifc

./obj_dir/sim_soc_ifc | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== soc_ifc_top_tb.sv ====
//////////////////////////////////////////////////
// Testbench for the SoC interface top level
// Replays APB transfers, sideband changes and
// output checks listed in soc_ifc_cases.txt
//////////////////////////////////////////////////

`timescale 1ns/1ps

module soc_ifc_top_tb;

    typedef struct packed {
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
    } case_t;

    logic        clk = 1'b0;
    logic        cptra_noncore_rst_b;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] pauser;
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;
    logic [1:0]  device_lifecycle;
    logic        debug_locked;
    logic [31:0] generic_input;
    logic        iccm_axs_blocked;
    logic [31:0] generic_output;
    logic        ready_for_fw_push;
    logic        ready_for_runtime;
    logic        mailbox_flow_done;
    logic        fuse_wr_done;
    logic        error_intr;
    logic        notif_intr;

    case_t cases[$];
    int    n_cases;
    int    errors;
    int    failed_cases;
    bit    loaded;

    always #5 clk = ~clk;

    soc_ifc_top u_soc_ifc_top (
        .clk(clk), .cptra_noncore_rst_b(cptra_noncore_rst_b),
        .paddr_i(paddr), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .pwdata_i(pwdata), .pauser_i(pauser),
        .pready_o(pready), .prdata_o(prdata), .pslverr_o(pslverr),
        .device_lifecycle_i(device_lifecycle), .debug_locked_i(debug_locked),
        .generic_input_i(generic_input), .iccm_axs_blocked_i(iccm_axs_blocked),
        .generic_output_o(generic_output), .ready_for_fw_push_o(ready_for_fw_push),
        .ready_for_runtime_o(ready_for_runtime), .mailbox_flow_done_o(mailbox_flow_done),
        .fuse_wr_done_o(fuse_wr_done), .soc_ifc_error_intr_o(error_intr),
        .soc_ifc_notif_intr_o(notif_intr)
    );

    bind soc_ifc_top soc_ifc_top_sva u_soc_ifc_top_sva (
        .clk(clk), .cptra_noncore_rst_b(cptra_noncore_rst_b),
        .psel_i(psel_i), .penable_i(penable_i), .pready_i(pready_o), .pslverr_i(pslverr_o),
        .intr_en_i(intr_en), .error_intr_i(soc_ifc_error_intr_o),
        .notif_intr_i(soc_ifc_notif_intr_o)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          code;
        string       line;
        logic [7:0]  op;
        logic [31:0] a, b, c, d, e;
        fd = $fopen("soc_ifc_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open soc_ifc_cases.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                // Skip comments and blank lines
                if (line.len() > 1 && line[0] != "#") begin
                    code = $sscanf(line, "%c %h %h %h %h %h", op, a, b, c, d, e);
                    if (code == 6) begin
                        cases.push_back({op, a, b, c, d, e});
                    end else begin
                        $display("malformed line in cases file: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
        n_cases = cases.size();
        if (n_cases == 0) begin
            $display("no test steps were loaded");
            errors++;
        end
        loaded = 1'b1;
    endtask

    // Setup cycle, then access until pready; one wait state expected
    task automatic apb_transfer(input logic write, input logic [31:0] addr,
                                input logic [31:0] data, input logic [31:0] user,
                                output logic [31:0] rdata, output logic slverr);
        int waits;
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr[11:0];
        pwdata  = data;
        pauser  = user;
        @(posedge clk);
        #1;
        penable = 1'b1;
        waits   = 0;
        @(negedge clk);
        while (!pready && waits < 8) begin
            waits++;
            @(negedge clk);
        end
        assert (pready) else begin
            $display("pready_o never came for the transfer to address %h", addr);
            errors++;
        end
        check_value("wait_states", 32'd1, waits);
        rdata  = prdata;
        slverr = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic run_case(input int idx);
        case_t       c;
        int          errs_before;
        logic [31:0] rdata;
        logic        slverr;
        c           = cases[idx];
        errs_before = errors;
        case (c.op)
            "W", "R": begin
                apb_transfer(c.op == "W", c.a, c.b, c.c, rdata, slverr);
                check_value("pslverr_o", c.e, {31'b0, slverr});
                // Read data is only defined for accepted reads
                if (c.op == "R" && c.e == 32'h0) begin
                    check_value("prdata_o", c.d, rdata);
                end
            end
            "S": begin
                @(posedge clk);
                #1;
                debug_locked     = c.a[0];
                generic_input    = c.b;
                iccm_axs_blocked = c.c[0];
                device_lifecycle = c.d[1:0];
            end
            "O": begin
                @(negedge clk);
                check_value("ready_for_fw_push_o", {31'b0, c.a[0]}, {31'b0, ready_for_fw_push});
                check_value("ready_for_runtime_o", {31'b0, c.a[1]}, {31'b0, ready_for_runtime});
                check_value("mailbox_flow_done_o", {31'b0, c.a[2]}, {31'b0, mailbox_flow_done});
                check_value("fuse_wr_done_o", {31'b0, c.a[3]}, {31'b0, fuse_wr_done});
                check_value("generic_output_o", c.b, generic_output);
                check_value("soc_ifc_error_intr_o", {31'b0, c.c[0]}, {31'b0, error_intr});
                check_value("soc_ifc_notif_intr_o", {31'b0, c.c[1]}, {31'b0, notif_intr});
            end
            default: begin
                $display("step %0d has an unknown operation %c", idx, c.op);
                errors++;
            end
        endcase
        if (errors == errs_before) begin
            $display("step %0d %c %h: ok", idx, c.op, c.a);
        end else begin
            $display("step %0d %c %h: failed", idx, c.op, c.a);
            failed_cases++;
        end
    endtask

    initial begin : main
        $timeformat(-9, 0, " ns", 0);
        cptra_noncore_rst_b = 1'b0;
        psel             = 1'b0;
        penable          = 1'b0;
        pwrite           = 1'b0;
        paddr            = '0;
        pwdata           = '0;
        pauser           = '0;
        device_lifecycle = '0;
        debug_locked     = 1'b0;
        generic_input    = '0;
        iccm_axs_blocked = 1'b0;
        errors           = 0;
        failed_cases     = 0;
        load_cases();
        repeat (4) @(posedge clk);
        #1;
        cptra_noncore_rst_b = 1'b1;
        for (int i = 0; i < n_cases; i++) begin
            run_case(i);
        end
        $display("steps: %0d, failed steps: %0d, errors: %0d", n_cases, failed_cases, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Each step takes well under 10 cycles
    initial begin : watchdog
        wait (loaded);
        repeat (n_cases * 10 + 100) @(posedge clk);
        $display("timeout: steps did not finish within %0d cycles", n_cases * 10 + 100);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== soc_ifc_top_sva.sv ====
//////////////////////////////////////////////////
// Bound checks on the SoC interface top level
// APB response timing and interrupt gating
//////////////////////////////////////////////////

`timescale 1ns/1ps

module soc_ifc_top_sva (
    input logic                               clk,
    input logic                               cptra_noncore_rst_b,
    input logic                               psel_i,
    input logic                               penable_i,
    input logic                               pready_i,
    input logic                               pslverr_i,
    input logic [soc_ifc_reg_pkg::INTR_W-1:0] intr_en_i,
    input logic                               error_intr_i,
    input logic                               notif_intr_i
);

    // Single-cycle pready right after an access cycle
    pready_pulse_a: assert property (@(posedge clk) disable iff (!cptra_noncore_rst_b)
        pready_i |-> $past(psel_i && penable_i) ##1 !pready_i)
        else $error("pready_o is not a one-cycle pulse after an access cycle");

    pslverr_with_pready_a: assert property (@(posedge clk) disable iff (!cptra_noncore_rst_b)
        pslverr_i |-> pready_i)
        else $error("pslverr_o asserted without pready_o");

    // Outputs are registered, so each follows its own enable one cycle later
    intr_gated_a: assert property (@(posedge clk) disable iff (!cptra_noncore_rst_b)
        (!error_intr_i || $past(intr_en_i[0])) && (!notif_intr_i || $past(intr_en_i[1])))
        else $error("interrupt output high while its enable is low");

endmodule

// ==== soc_ifc_top.sv ====
//////////////////////////////////////////////////
// SoC interface top level
// APB register path with flow, fuse, PAUSER and
// TRNG registers plus two interrupt outputs
//////////////////////////////////////////////////

`timescale 1ns/1ps

module soc_ifc_top #(
    parameter int APB_ADDR_W    = 12,
    parameter int APB_USER_W    = 32,
    parameter int NUM_UDS_WORDS = 4
) (
    input  logic                                    clk,
    input  logic                                    cptra_noncore_rst_b,
    input  logic [APB_ADDR_W-1:0]                   paddr_i,
    input  logic                                    psel_i,
    input  logic                                    penable_i,
    input  logic                                    pwrite_i,
    input  logic [soc_ifc_pkg::SOC_IFC_DATA_W-1:0]  pwdata_i,
    input  logic [APB_USER_W-1:0]                   pauser_i,
    output logic                                    pready_o,
    output logic [soc_ifc_pkg::SOC_IFC_DATA_W-1:0]  prdata_o,
    output logic                                    pslverr_o,
    input  logic [soc_ifc_reg_pkg::LIFECYCLE_W-1:0] device_lifecycle_i,
    input  logic                                    debug_locked_i,
    input  logic [soc_ifc_pkg::SOC_IFC_DATA_W-1:0]  generic_input_i,
    input  logic                                    iccm_axs_blocked_i,
    output logic [soc_ifc_pkg::SOC_IFC_DATA_W-1:0]  generic_output_o,
    output logic                                    ready_for_fw_push_o,
    output logic                                    ready_for_runtime_o,
    output logic                                    mailbox_flow_done_o,
    output logic                                    fuse_wr_done_o,
    output logic                                    soc_ifc_error_intr_o,
    output logic                                    soc_ifc_notif_intr_o
);

    logic [soc_ifc_reg_pkg::INTR_W-1:0] err_w1c;
    logic [soc_ifc_reg_pkg::INTR_W-1:0] notif_w1c;
    logic                               intr_en_we;
    logic [soc_ifc_reg_pkg::INTR_W-1:0] intr_en_wdata;
    logic                               bad_access;
    logic [soc_ifc_reg_pkg::INTR_W-1:0] err_sts;
    logic [soc_ifc_reg_pkg::INTR_W-1:0] notif_sts;
    logic [soc_ifc_reg_pkg::INTR_W-1:0] intr_en;

    soc_ifc_req_if #(.APB_ADDR_W(APB_ADDR_W), .APB_USER_W(APB_USER_W)) u_req_if ();

    apb_slv_sif #(.APB_ADDR_W(APB_ADDR_W), .APB_USER_W(APB_USER_W)) u_apb_slv_sif (
        .clk                 (clk),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .paddr_i             (paddr_i),
        .psel_i              (psel_i),
        .penable_i           (penable_i),
        .pwrite_i            (pwrite_i),
        .pwdata_i            (pwdata_i),
        .pauser_i            (pauser_i),
        .pready_o            (pready_o),
        .prdata_o            (prdata_o),
        .pslverr_o           (pslverr_o),
        .req_if              (u_req_if.requester)
    );

    soc_ifc_regs #(
        .APB_ADDR_W    (APB_ADDR_W),
        .APB_USER_W    (APB_USER_W),
        .NUM_UDS_WORDS (NUM_UDS_WORDS)
    ) u_soc_ifc_regs (
        .clk                 (clk),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .req_if              (u_req_if.responder),
        .device_lifecycle_i  (device_lifecycle_i),
        .debug_locked_i      (debug_locked_i),
        .generic_input_i     (generic_input_i),
        .generic_output_o    (generic_output_o),
        .ready_for_fw_push_o (ready_for_fw_push_o),
        .ready_for_runtime_o (ready_for_runtime_o),
        .mailbox_flow_done_o (mailbox_flow_done_o),
        .fuse_wr_done_o      (fuse_wr_done_o),
        .err_w1c_o           (err_w1c),
        .notif_w1c_o         (notif_w1c),
        .intr_en_we_o        (intr_en_we),
        .intr_en_wdata_o     (intr_en_wdata),
        .bad_access_o        (bad_access),
        .err_sts_i           (err_sts),
        .notif_sts_i         (notif_sts),
        .intr_en_i           (intr_en)
    );

    soc_ifc_intr u_soc_ifc_intr (
        .clk                 (clk),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .debug_locked_i      (debug_locked_i),
        .iccm_axs_blocked_i  (iccm_axs_blocked_i),
        .bad_access_i        (bad_access),
        .err_w1c_i           (err_w1c),
        .notif_w1c_i         (notif_w1c),
        .intr_en_we_i        (intr_en_we),
        .intr_en_wdata_i     (intr_en_wdata),
        .err_sts_o           (err_sts),
        .notif_sts_o         (notif_sts),
        .intr_en_o           (intr_en),
        .error_intr_o        (soc_ifc_error_intr_o),
        .notif_intr_o        (soc_ifc_notif_intr_o)
    );

endmodule

// ==== soc_ifc_intr.sv ====
//////////////////////////////////////////////////
// Interrupt status, enable and output logic
// Error and notification events set sticky status
// bits cleared by write-1-to-clear from software
//////////////////////////////////////////////////

`timescale 1ns/1ps

module soc_ifc_intr (
    input  logic                               clk,
    input  logic                               cptra_noncore_rst_b,
    input  logic                               debug_locked_i,
    input  logic                               iccm_axs_blocked_i,
    input  logic                               bad_access_i,
    input  logic [soc_ifc_reg_pkg::INTR_W-1:0] err_w1c_i,
    input  logic [soc_ifc_reg_pkg::INTR_W-1:0] notif_w1c_i,
    input  logic                               intr_en_we_i,
    input  logic [soc_ifc_reg_pkg::INTR_W-1:0] intr_en_wdata_i,
    output logic [soc_ifc_reg_pkg::INTR_W-1:0] err_sts_o,
    output logic [soc_ifc_reg_pkg::INTR_W-1:0] notif_sts_o,
    output logic [soc_ifc_reg_pkg::INTR_W-1:0] intr_en_o,
    output logic                               error_intr_o,
    output logic                               notif_intr_o
);

    logic                               debug_locked_q;
    logic [soc_ifc_reg_pkg::INTR_W-1:0] err_set;
    logic [soc_ifc_reg_pkg::INTR_W-1:0] notif_set;

    // Event sources; any edge of debug_locked notifies
    always_comb begin
        err_set   = '0;
        notif_set = '0;
        err_set[soc_ifc_reg_pkg::ERR_ICCM_BIT]         = iccm_axs_blocked_i;
        err_set[soc_ifc_reg_pkg::ERR_BAD_ACCESS_BIT]   = bad_access_i;
        notif_set[soc_ifc_reg_pkg::NOTIF_DEBUG_LOCK_BIT] = debug_locked_i ^ debug_locked_q;
    end

    always_ff @(posedge clk or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            debug_locked_q <= 1'b0;
            err_sts_o      <= '0;
            notif_sts_o    <= '0;
            intr_en_o      <= '0;
            error_intr_o   <= 1'b0;
            notif_intr_o   <= 1'b0;
        end else begin
            debug_locked_q <= debug_locked_i;
            // Set wins over a clear in the same cycle
            err_sts_o   <= err_set | (err_sts_o & ~err_w1c_i);
            notif_sts_o <= notif_set | (notif_sts_o & ~notif_w1c_i);
            if (intr_en_we_i) begin
                intr_en_o <= intr_en_wdata_i;
            end
            // Enable bit0 gates errors, bit1 notifications
            error_intr_o <= intr_en_o[0] && (|err_sts_o);
            notif_intr_o <= intr_en_o[1] && (|notif_sts_o);
        end
    end

endmodule

// ==== soc_ifc_regs.sv ====
//////////////////////////////////////////////////
// SoC interface register block
// Decodes register requests, holds flow, fuse,
// PAUSER and TRNG storage and hands interrupt
// register accesses to the interrupt block
//////////////////////////////////////////////////

`timescale 1ns/1ps

module soc_ifc_regs #(
    parameter int APB_ADDR_W    = 12,
    parameter int APB_USER_W    = 32,
    // Bank must end below VALID_PAUSER_OFS
    parameter int NUM_UDS_WORDS = 4
) (
    input  logic                                    clk,
    input  logic                                    cptra_noncore_rst_b,
    soc_ifc_req_if.responder                        req_if,
    input  logic [soc_ifc_reg_pkg::LIFECYCLE_W-1:0] device_lifecycle_i,
    input  logic                                    debug_locked_i,
    input  logic [soc_ifc_pkg::SOC_IFC_DATA_W-1:0]  generic_input_i,
    output logic [soc_ifc_pkg::SOC_IFC_DATA_W-1:0]  generic_output_o,
    output logic                                    ready_for_fw_push_o,
    output logic                                    ready_for_runtime_o,
    output logic                                    mailbox_flow_done_o,
    output logic                                    fuse_wr_done_o,
    output logic [soc_ifc_reg_pkg::INTR_W-1:0]      err_w1c_o,
    output logic [soc_ifc_reg_pkg::INTR_W-1:0]      notif_w1c_o,
    output logic                                    intr_en_we_o,
    output logic [soc_ifc_reg_pkg::INTR_W-1:0]      intr_en_wdata_o,
    output logic                                    bad_access_o,
    input  logic [soc_ifc_reg_pkg::INTR_W-1:0]      err_sts_i,
    input  logic [soc_ifc_reg_pkg::INTR_W-1:0]      notif_sts_i,
    input  logic [soc_ifc_reg_pkg::INTR_W-1:0]      intr_en_i
);

    localparam int DW = soc_ifc_pkg::SOC_IFC_DATA_W;

    logic [soc_ifc_reg_pkg::REG_OFS_W-1:0] ofs;
    logic                                  in_range;
    logic                                  wr_en;
    logic                                  mapped;
    logic                                  read_only;
    logic [NUM_UDS_WORDS-1:0]              uds_hit;
    logic [DW-1:0]                         uds_rdata;

    // bit0 ready_for_fw, bit1 ready_for_runtime, bit2 mailbox_flow_done
    logic [2:0]                            flow_q;
    logic [DW-1:0]                         gen_out_q;
    logic                                  fuse_done_q;
    logic [APB_USER_W-1:0]                 valid_pauser_q;
    logic                                  pauser_lock_q;
    logic [DW-1:0]                         uds_q [NUM_UDS_WORDS];
    logic [DW-1:0]                         trng_q;

    assign ofs      = req_if.addr[soc_ifc_reg_pkg::REG_OFS_W-1:0];
    assign in_range = (req_if.addr[APB_ADDR_W-1:soc_ifc_reg_pkg::REG_OFS_W] == '0);
    assign wr_en    = req_if.req_dv && (req_if.op == soc_ifc_pkg::REQ_WRITE) && in_range;

    // UDS words sit at consecutive word offsets
    always_comb begin
        uds_rdata = '0;
        for (int i = 0; i < NUM_UDS_WORDS; i++) begin
            uds_hit[i] = in_range &&
                (ofs == soc_ifc_reg_pkg::FUSE_UDS_BASE_OFS +
                        soc_ifc_reg_pkg::REG_OFS_W'(4 * i));
            if (uds_hit[i]) begin
                uds_rdata = uds_rdata | uds_q[i];
            end
        end
    end

    //////////////////////////////////////////////////
    // Read decode and access errors
    //////////////////////////////////////////////////
    always_comb begin
        mapped    = in_range;
        read_only = 1'b0;
        case (ofs)
            soc_ifc_reg_pkg::FLOW_STATUS_OFS:  req_if.rdata = DW'(flow_q);
            soc_ifc_reg_pkg::SECURITY_STATE_OFS: begin
                req_if.rdata = DW'({debug_locked_i, device_lifecycle_i});
                read_only    = 1'b1;
            end
            soc_ifc_reg_pkg::GENERIC_IN_OFS: begin
                req_if.rdata = generic_input_i;
                read_only    = 1'b1;
            end
            soc_ifc_reg_pkg::GENERIC_OUT_OFS:  req_if.rdata = gen_out_q;
            soc_ifc_reg_pkg::FUSE_WR_DONE_OFS: req_if.rdata = DW'(fuse_done_q);
            soc_ifc_reg_pkg::VALID_PAUSER_OFS: req_if.rdata = DW'(valid_pauser_q);
            soc_ifc_reg_pkg::PAUSER_LOCK_OFS:  req_if.rdata = DW'(pauser_lock_q);
            soc_ifc_reg_pkg::TRNG_DATA_OFS:    req_if.rdata = trng_q;
            soc_ifc_reg_pkg::ERR_STS_OFS:      req_if.rdata = DW'(err_sts_i);
            soc_ifc_reg_pkg::NOTIF_STS_OFS:    req_if.rdata = DW'(notif_sts_i);
            soc_ifc_reg_pkg::INTR_EN_OFS:      req_if.rdata = DW'(intr_en_i);
            default: begin
                req_if.rdata = uds_rdata;
                mapped       = |uds_hit;
            end
        endcase
    end

    assign req_if.error = !mapped || ((req_if.op == soc_ifc_pkg::REQ_WRITE) && read_only);
    assign bad_access_o = req_if.req_dv && req_if.error;

    // Interrupt register writes are applied in the interrupt block
    assign err_w1c_o = (wr_en && ofs == soc_ifc_reg_pkg::ERR_STS_OFS) ?
                       req_if.wdata[soc_ifc_reg_pkg::INTR_W-1:0] : '0;
    assign notif_w1c_o = (wr_en && ofs == soc_ifc_reg_pkg::NOTIF_STS_OFS) ?
                         req_if.wdata[soc_ifc_reg_pkg::INTR_W-1:0] : '0;
    assign intr_en_we_o    = wr_en && (ofs == soc_ifc_reg_pkg::INTR_EN_OFS);
    assign intr_en_wdata_o = req_if.wdata[soc_ifc_reg_pkg::INTR_W-1:0];

    //////////////////////////////////////////////////
    // Control registers and locks
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            flow_q         <= '0;
            gen_out_q      <= '0;
            fuse_done_q    <= 1'b0;
            valid_pauser_q <= '0;
            pauser_lock_q  <= 1'b0;
        end else if (wr_en) begin
            case (ofs)
                soc_ifc_reg_pkg::FLOW_STATUS_OFS:  flow_q <= req_if.wdata[2:0];
                soc_ifc_reg_pkg::GENERIC_OUT_OFS:  gen_out_q <= req_if.wdata;
                // Sticky until reset
                soc_ifc_reg_pkg::FUSE_WR_DONE_OFS: fuse_done_q <= fuse_done_q | req_if.wdata[0];
                soc_ifc_reg_pkg::VALID_PAUSER_OFS: begin
                    if (!pauser_lock_q) begin
                        valid_pauser_q <= APB_USER_W'(req_if.wdata);
                    end
                end
                soc_ifc_reg_pkg::PAUSER_LOCK_OFS: begin
                    if (!pauser_lock_q) begin
                        pauser_lock_q <= req_if.wdata[0];
                    end
                end
                default: ;
            endcase
        end
    end

    // UDS locks on fuse done, TRNG only from the valid PAUSER
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_UDS_WORDS; i++) begin
            if (wr_en && uds_hit[i] && !fuse_done_q) begin
                uds_q[i] <= req_if.wdata;
            end
        end
        if (wr_en && ofs == soc_ifc_reg_pkg::TRNG_DATA_OFS && req_if.user == valid_pauser_q) begin
            trng_q <= req_if.wdata;
        end
    end

    assign ready_for_fw_push_o = flow_q[0];
    assign ready_for_runtime_o = flow_q[1];
    assign mailbox_flow_done_o = flow_q[2];
    assign generic_output_o    = gen_out_q;
    assign fuse_wr_done_o      = fuse_done_q;

endmodule

// ==== apb_slv_sif.sv ====
//////////////////////////////////////////////////
// APB slave front end
// Issues one register request per transfer in the
// first access cycle and returns a registered
// response with a single wait state
//////////////////////////////////////////////////

`timescale 1ns/1ps

module apb_slv_sif #(
    parameter int APB_ADDR_W = 12,
    parameter int APB_USER_W = 32
) (
    input  logic                                   clk,
    input  logic                                   cptra_noncore_rst_b,
    input  logic [APB_ADDR_W-1:0]                  paddr_i,
    input  logic                                   psel_i,
    input  logic                                   penable_i,
    input  logic                                   pwrite_i,
    input  logic [soc_ifc_pkg::SOC_IFC_DATA_W-1:0] pwdata_i,
    input  logic [APB_USER_W-1:0]                  pauser_i,
    output logic                                   pready_o,
    output logic [soc_ifc_pkg::SOC_IFC_DATA_W-1:0] prdata_o,
    output logic                                   pslverr_o,
    soc_ifc_req_if.requester                       req_if
);

    soc_ifc_pkg::apb_state_e state_q;

    // Request goes out once, in the first access cycle
    assign req_if.req_dv = (state_q == soc_ifc_pkg::APB_ACCESS) && psel_i && penable_i;
    assign req_if.op     = pwrite_i ? soc_ifc_pkg::REQ_WRITE : soc_ifc_pkg::REQ_READ;
    assign req_if.addr   = paddr_i;
    assign req_if.wdata  = pwdata_i;
    assign req_if.user   = pauser_i;

    //////////////////////////////////////////////////
    // Transfer state
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            state_q   <= soc_ifc_pkg::APB_IDLE;
            pready_o  <= 1'b0;
            pslverr_o <= 1'b0;
        end else begin
            pready_o  <= req_if.req_dv;
            pslverr_o <= req_if.req_dv && req_if.error;
            case (state_q)
                // Setup phase seen, access follows
                soc_ifc_pkg::APB_IDLE: begin
                    if (psel_i && !penable_i) begin
                        state_q <= soc_ifc_pkg::APB_ACCESS;
                    end
                end
                soc_ifc_pkg::APB_ACCESS: begin
                    if (req_if.req_dv) begin
                        state_q <= soc_ifc_pkg::APB_RESP;
                    end else if (!psel_i) begin
                        state_q <= soc_ifc_pkg::APB_IDLE;
                    end
                end
                // pready_o is high for this one cycle
                soc_ifc_pkg::APB_RESP: state_q <= soc_ifc_pkg::APB_IDLE;
                default:               state_q <= soc_ifc_pkg::APB_IDLE;
            endcase
        end
    end

    // Read data captured with the request
    always_ff @(posedge clk) begin
        if (req_if.req_dv) begin
            prdata_o <= req_if.rdata;
        end
    end

endmodule

// ==== soc_ifc_req_if.sv ====
//////////////////////////////////////////////////
// Single-cycle register request between the APB
// front end and the register block; the response
// is valid in the same cycle as req_dv
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface soc_ifc_req_if #(
    parameter int APB_ADDR_W = 12,
    parameter int APB_USER_W = 32
);

    logic                                   req_dv;
    soc_ifc_pkg::req_op_e                   op;
    logic [APB_ADDR_W-1:0]                  addr;
    logic [soc_ifc_pkg::SOC_IFC_DATA_W-1:0] wdata;
    logic [APB_USER_W-1:0]                  user;
    logic [soc_ifc_pkg::SOC_IFC_DATA_W-1:0] rdata;
    logic                                   error;

    modport requester (output req_dv, op, addr, wdata, user, input rdata, error);

    modport responder (input req_dv, op, addr, wdata, user, output rdata, error);

endinterface

// ==== soc_ifc_reg_pkg.sv ====
//////////////////////////////////////////////////
// Register map of the SoC interface block
// Byte offsets, field widths and interrupt status
// bit positions shared by RTL and testbench
//////////////////////////////////////////////////

package soc_ifc_reg_pkg;

    // Offsets are decoded from the low address bits
    parameter int REG_OFS_W = 8;

    parameter logic [REG_OFS_W-1:0] FLOW_STATUS_OFS    = 8'h00;
    parameter logic [REG_OFS_W-1:0] SECURITY_STATE_OFS = 8'h04;
    parameter logic [REG_OFS_W-1:0] GENERIC_IN_OFS     = 8'h08;
    parameter logic [REG_OFS_W-1:0] GENERIC_OUT_OFS    = 8'h0C;
    parameter logic [REG_OFS_W-1:0] FUSE_WR_DONE_OFS   = 8'h10;
    parameter logic [REG_OFS_W-1:0] FUSE_UDS_BASE_OFS  = 8'h20;
    parameter logic [REG_OFS_W-1:0] VALID_PAUSER_OFS   = 8'h40;
    parameter logic [REG_OFS_W-1:0] PAUSER_LOCK_OFS    = 8'h44;
    parameter logic [REG_OFS_W-1:0] TRNG_DATA_OFS      = 8'h48;
    parameter logic [REG_OFS_W-1:0] ERR_STS_OFS        = 8'h50;
    parameter logic [REG_OFS_W-1:0] NOTIF_STS_OFS      = 8'h54;
    parameter logic [REG_OFS_W-1:0] INTR_EN_OFS        = 8'h58;

    // Field widths
    parameter int LIFECYCLE_W = 2;
    parameter int INTR_W      = 2;

    // Error status bits
    parameter int ERR_ICCM_BIT       = 0;
    parameter int ERR_BAD_ACCESS_BIT = 1;

    // Notification status bits
    parameter int NOTIF_DEBUG_LOCK_BIT = 0;

endpackage

// ==== soc_ifc_pkg.sv ====
//////////////////////////////////////////////////
// Common definitions for the SoC interface block
// Bus data width, request opcodes and the APB
// slave state encoding
//////////////////////////////////////////////////

package soc_ifc_pkg;

    // Width of every register and APB data word
    parameter int SOC_IFC_DATA_W = 32;

    // Opcode carried with each register request
    typedef enum logic {
        REQ_READ  = 1'b0,
        REQ_WRITE = 1'b1
    } req_op_e;

    // APB slave transfer tracking
    typedef enum logic [1:0] {
        APB_IDLE   = 2'b00,
        APB_ACCESS = 2'b01,
        APB_RESP   = 2'b10
    } apb_state_e;

endpackage
